// File: verilog/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Address split: tag | index | byte offset
`define ICACHE_TAG_W     20
`define ICACHE_INDEX_W   7
`define ICACHE_OFFSET_W  5
`define ICACHE_ADDR_W    32

// Geometry
`define ICACHE_SETS      128
`define ICACHE_WAYS      2
`define ICACHE_BANKS     8

// Words and lines
`define ICACHE_WORD_W    32
`define ICACHE_LINE_W    256

// Wide enough to hold a full line count of 8
`define ICACHE_RNUM_W    4

`endif

// File: verilog/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // One cache line, seen flat or as its bank words
    // Bank 0 sits in the lowest bits
    typedef union packed {
        logic [`ICACHE_LINE_W-1:0]                     flat;
        logic [`ICACHE_BANKS-1:0][`ICACHE_WORD_W-1:0] banks;
    } cache_line_u;

endpackage

// File: verilog/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tag_array (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       lookup_en,
    input  logic                       refill_we,
    input  logic                       rp_way,
    input  logic [`ICACHE_INDEX_W-1:0] ram_index,
    input  logic [`ICACHE_INDEX_W-1:0] rb_index,
    input  logic [`ICACHE_TAG_W-1:0]   rb_tag,
    output logic [`ICACHE_WAYS-1:0]    way_hit
);

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
        logic [`ICACHE_TAG_W-1:0] tag_q;
        logic [`ICACHE_SETS-1:0]  valid_q;
        logic                     way_sel;

        assign way_sel = (rp_way == 1'(w));

        // Tag RAM, read on lookup and written only for the victim way
        always_ff @(posedge clk) begin
            if (refill_we && way_sel) begin
                tag_mem[ram_index] <= rb_tag;
            end
            if (lookup_en) begin
                tag_q <= tag_mem[ram_index];
            end
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_q <= '0;
            end else if (refill_we && way_sel) begin
                valid_q[rb_index] <= 1'b1;
            end
        end

        // Compare against the buffered request
        assign way_hit[w] = valid_q[rb_index] && (tag_q == rb_tag);
    end

endmodule

// File: verilog/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_data_array (
    input  logic                       clk,
    input  logic                       lookup_en,
    input  logic                       refill_we,
    input  logic                       rp_way,
    input  logic [`ICACHE_INDEX_W-1:0] ram_index,
    input  icache_pkg::cache_line_u    ret_data,
    input  logic [`ICACHE_WAYS-1:0]    way_hit,
    output icache_pkg::cache_line_u    load_line
);

    import icache_pkg::*;

    cache_line_u way_line [`ICACHE_WAYS];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic way_we;

        assign way_we = refill_we && (rp_way == 1'(w));

        for (genvar b = 0; b < `ICACHE_BANKS; b++) begin : g_bank
            logic [`ICACHE_WORD_W-1:0] bank_mem [`ICACHE_SETS];
            logic [`ICACHE_WORD_W-1:0] bank_q;

            always_ff @(posedge clk) begin
                if (way_we) begin
                    bank_mem[ram_index] <= ret_data.banks[b];
                end
                if (lookup_en) begin
                    bank_q <= bank_mem[ram_index];
                end
            end

            assign way_line[w].banks[b] = bank_q;
        end
    end

    // Zero when neither way hits
    always_comb begin
        load_line.flat = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                load_line.flat = load_line.flat | way_line[w].flat;
            end
        end
    end

endmodule

// File: verilog/icache_plru.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_plru (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [`ICACHE_INDEX_W-1:0] rb_index,
    input  logic                       touch_en,
    input  logic                       touch_way,
    input  logic                       lookup_miss,
    output logic                       rp_way
);

    // One MRU bit per way and set
    logic [`ICACHE_SETS-1:0] mru_q [`ICACHE_WAYS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                mru_q[w] <= '0;
            end
        end else if (touch_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                mru_q[w][rb_index] <= (touch_way == 1'(w));
            end
        end
    end

    // Victim is the first way not marked recently used
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rp_way <= 1'b0;
        end else if (lookup_miss) begin
            if (!mru_q[0][rb_index]) begin
                rp_way <= 1'b0;
            end else if (!mru_q[1][rb_index]) begin
                rp_way <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic [`ICACHE_TAG_W-1:0]    tag,
    input  logic [`ICACHE_INDEX_W-1:0]  index,
    input  logic [`ICACHE_OFFSET_W-1:0] offset,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  icache_pkg::cache_line_u     ret_data,
    input  logic [`ICACHE_WAYS-1:0]     way_hit,
    input  icache_pkg::cache_line_u     load_line,
    input  logic                        rp_way,
    output logic                        addr_ok,
    output logic                        data_ok,
    output icache_pkg::cache_line_u     rdata,
    output logic [`ICACHE_RNUM_W-1:0]   rnum,
    output logic                        rd_req,
    output logic [`ICACHE_ADDR_W-1:0]   rd_addr,
    output logic                        lookup_en,
    output logic                        refill_we,
    output logic [`ICACHE_INDEX_W-1:0]  ram_index,
    output logic [`ICACHE_INDEX_W-1:0]  rb_index,
    output logic [`ICACHE_TAG_W-1:0]    rb_tag,
    output logic                        touch_en,
    output logic                        touch_way,
    output logic                        lookup_miss
);

    localparam logic [3:0] S_IDLE    = 4'b0001;
    localparam logic [3:0] S_LOOKUP  = 4'b0010;
    localparam logic [3:0] S_REPLACE = 4'b0100;
    localparam logic [3:0] S_REFILL  = 4'b1000;

    localparam logic [`ICACHE_RNUM_W-1:0] LINE_WORDS = `ICACHE_BANKS;

    logic [3:0]                  state;
    logic [3:0]                  next_state;
    logic [`ICACHE_OFFSET_W-1:0] rb_offset;
    logic [`ICACHE_RNUM_W-1:0]   word_idx;
    logic                        cache_hit;
    logic                        hit_done;

    assign cache_hit = |way_hit;
    assign hit_done  = state[1] && cache_hit;

    // A hit in LOOKUP frees the buffer for the next request
    assign addr_ok   = valid && (state[0] || hit_done);
    assign lookup_en = addr_ok;
    assign refill_we = state[3] && ret_valid;
    assign ram_index = lookup_en ? index : rb_index;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
        end
    end

    assign lookup_miss = state[1] && !cache_hit;
    assign touch_en    = hit_done || state[2];
    assign touch_way   = state[1] ? way_hit[1] : rp_way;

    assign data_ok    = hit_done || refill_we;
    assign rdata.flat = ({`ICACHE_LINE_W{hit_done}} & load_line.flat) |
                        ({`ICACHE_LINE_W{refill_we}} & ret_data.flat);

    assign word_idx = {1'b0, rb_offset[`ICACHE_OFFSET_W-1:2]};
    assign rnum     = LINE_WORDS - word_idx;

    assign rd_req  = state[2];
    assign rd_addr = {rb_tag, rb_index, {`ICACHE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            S_IDLE:    next_state = addr_ok ? S_LOOKUP : S_IDLE;
            S_LOOKUP: begin
                if (!cache_hit) begin
                    next_state = S_REPLACE;
                end else if (addr_ok) begin
                    next_state = S_LOOKUP;
                end else begin
                    next_state = S_IDLE;
                end
            end
            S_REPLACE: next_state = rd_rdy ? S_REFILL : S_REPLACE;
            S_REFILL:  next_state = ret_valid ? S_IDLE : S_REFILL;
            default:   next_state = S_IDLE;
        endcase
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic [`ICACHE_TAG_W-1:0]    tag,
    input  logic [`ICACHE_INDEX_W-1:0]  index,
    input  logic [`ICACHE_OFFSET_W-1:0] offset,
    output logic                        addr_ok,
    output logic                        data_ok,
    output icache_pkg::cache_line_u     rdata,
    output logic [`ICACHE_RNUM_W-1:0]   rnum,
    output logic                        rd_req,
    output logic [`ICACHE_ADDR_W-1:0]   rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  icache_pkg::cache_line_u     ret_data
);

    import icache_pkg::*;

    logic                       lookup_en;
    logic                       refill_we;
    logic [`ICACHE_INDEX_W-1:0] ram_index;
    logic [`ICACHE_INDEX_W-1:0] rb_index;
    logic [`ICACHE_TAG_W-1:0]   rb_tag;
    logic [`ICACHE_WAYS-1:0]    way_hit;
    cache_line_u                load_line;
    logic                       rp_way;
    logic                       touch_en;
    logic                       touch_way;
    logic                       lookup_miss;

    icache_ctrl i_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .tag         (tag),
        .index       (index),
        .offset      (offset),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .way_hit     (way_hit),
        .load_line   (load_line),
        .rp_way      (rp_way),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rnum        (rnum),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .lookup_en   (lookup_en),
        .refill_we   (refill_we),
        .ram_index   (ram_index),
        .rb_index    (rb_index),
        .rb_tag      (rb_tag),
        .touch_en    (touch_en),
        .touch_way   (touch_way),
        .lookup_miss (lookup_miss)
    );

    icache_tag_array i_tag_array (
        .clk       (clk),
        .resetn    (resetn),
        .lookup_en (lookup_en),
        .refill_we (refill_we),
        .rp_way    (rp_way),
        .ram_index (ram_index),
        .rb_index  (rb_index),
        .rb_tag    (rb_tag),
        .way_hit   (way_hit)
    );

    icache_data_array i_data_array (
        .clk       (clk),
        .lookup_en (lookup_en),
        .refill_we (refill_we),
        .rp_way    (rp_way),
        .ram_index (ram_index),
        .ret_data  (ret_data),
        .way_hit   (way_hit),
        .load_line (load_line)
    );

    icache_plru i_plru (
        .clk         (clk),
        .resetn      (resetn),
        .rb_index    (rb_index),
        .touch_en    (touch_en),
        .touch_way   (touch_way),
        .lookup_miss (lookup_miss),
        .rp_way      (rp_way)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam time HALF_PERIOD = 10ns;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk = ~clk;
        end
    end

endmodule

// File: tb/icache_assert.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_assert (
    input logic                      clk,
    input logic                      resetn,
    input logic [`ICACHE_WAYS-1:0]   way_hit,
    input logic                      rd_req,
    input logic                      rd_rdy,
    input logic [`ICACHE_ADDR_W-1:0] rd_addr,
    input logic                      data_ok
);

    // At most one way may match a tag
    a_way_hit_onehot: assert property (
        @(posedge clk) disable iff (!resetn) $onehot0(way_hit)
    ) else $error("way_hit has more than one bit set");

    // Memory request held until accepted
    a_rd_req_hold: assert property (
        @(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> (rd_req && $stable(rd_addr))
    ) else $error("rd_req or rd_addr changed before rd_rdy");

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!resetn) !(data_ok && rd_req)
    ) else $error("data_ok and rd_req high together");

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb;

    import icache_pkg::*;

    localparam int MAX_WORDS = 256;

    logic                        clk;
    logic                        resetn;
    logic                        valid;
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
    logic                        addr_ok;
    logic                        data_ok;
    cache_line_u                 rdata;
    logic [`ICACHE_RNUM_W-1:0]   rnum;
    logic                        rd_req;
    logic [`ICACHE_ADDR_W-1:0]   rd_addr;
    logic                        rd_rdy;
    logic                        ret_valid;
    cache_line_u                 ret_data;

    logic [31:0] vec_mem [MAX_WORDS];
    int          n_vec;
    int          vec_idx;
    int          cycle;
    int          limit;

    // Accepted requests waiting for data_ok
    logic [`ICACHE_ADDR_W-1:0]   pend_addr [$];
    logic [`ICACHE_OFFSET_W-1:0] pend_off [$];
    bit                          pend_hit [$];
    int                          pend_cycle [$];

    tb_clock_gen i_clk (.clk(clk));

    icache_top i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    bind icache_top icache_assert i_assert (
        .clk     (clk),
        .resetn  (resetn),
        .way_hit (way_hit),
        .rd_req  (rd_req),
        .rd_rdy  (rd_rdy),
        .rd_addr (rd_addr),
        .data_ok (data_ok)
    );

    function automatic cache_line_u make_line(input logic [31:0] line_addr);
        cache_line_u line;
        for (int w = 0; w < `ICACHE_BANKS; w++) begin
            line.banks[w] = ((line_addr >> 2) + 32'(w)) ^ 32'h5A5A5A5A;
        end
        return line;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_line(input cache_line_u got, input cache_line_u exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL rdata got %h expected %h", got.flat, exp.flat));
        end
    endtask

    task automatic check_rnum(input logic [`ICACHE_RNUM_W-1:0] got,
                              input logic [`ICACHE_RNUM_W-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL rnum got %h expected %h", got, exp));
        end
    endtask

    task automatic check_addr(input logic [`ICACHE_ADDR_W-1:0] got,
                              input logic [`ICACHE_ADDR_W-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL rd_addr got %h expected %h", got, exp));
        end
    endtask

    task automatic drive_request();
        if (vec_idx < n_vec) begin
            valid  <= 1'b1;
            tag    <= vec_mem[4*vec_idx][`ICACHE_TAG_W-1:0];
            index  <= vec_mem[4*vec_idx+1][`ICACHE_INDEX_W-1:0];
            offset <= vec_mem[4*vec_idx+2][`ICACHE_OFFSET_W-1:0];
        end else begin
            valid <= 1'b0;
        end
    endtask

    // Memory model with random handshake delays
    initial begin
        int delay;
        logic [`ICACHE_ADDR_W-1:0] req_addr;
        void'($urandom(32'h59981d99));
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (rd_req === 1'b1) begin
                delay = int'($urandom % 4);
                repeat (delay) @(posedge clk);
                req_addr = rd_addr;
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                delay = 1 + int'($urandom % 4);
                repeat (delay - 1) @(posedge clk);
                ret_valid <= 1'b1;
                ret_data  <= make_line(req_addr);
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

    initial begin
        bit got_hit;
        logic [`ICACHE_ADDR_W-1:0] acc_addr;

        resetn    = 1'b0;
        valid     = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;

        // Unread words keep a pattern no tag can take
        for (int i = 0; i < MAX_WORDS; i++) begin
            vec_mem[i] = ~32'(i);
        end
        $readmemh("tb/icache_vectors.txt", vec_mem);
        n_vec = 0;
        while (4*n_vec < MAX_WORDS && vec_mem[4*n_vec] != ~32'(4*n_vec)) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            fail_now("No vectors were read from the vector file");
        end
        limit = n_vec * 20;

        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        vec_idx = 0;
        cycle   = 0;
        drive_request();

        while (vec_idx < n_vec || pend_cycle.size() != 0) begin
            @(posedge clk);
            cycle++;
            if (cycle > limit) begin
                fail_now("Timeout: requests did not complete within the cycle limit");
            end
            if (rd_req) begin
                if (pend_cycle.size() == 0) begin
                    fail_now("rd_req raised with no request outstanding");
                end
                check_addr(rd_addr, pend_addr[0]);
            end
            if (data_ok) begin
                if (pend_cycle.size() == 0) begin
                    fail_now("data_ok pulsed with no request outstanding");
                end
                got_hit = (cycle == pend_cycle[0] + 1);
                if (got_hit && !pend_hit[0]) begin
                    fail_now($sformatf("Request %h hit but a miss was expected", pend_addr[0]));
                end
                if (!got_hit && pend_hit[0]) begin
                    fail_now($sformatf("Request %h missed but a hit was expected", pend_addr[0]));
                end
                check_line(rdata, make_line(pend_addr[0]));
                check_rnum(rnum, `ICACHE_RNUM_W'(`ICACHE_BANKS - pend_off[0][4:2]));
                void'(pend_addr.pop_front());
                void'(pend_off.pop_front());
                void'(pend_hit.pop_front());
                void'(pend_cycle.pop_front());
            end
            if (valid && addr_ok) begin
                if (pend_cycle.size() != 0) begin
                    fail_now("New request accepted before the outstanding miss ended");
                end
                acc_addr = {tag, index, {`ICACHE_OFFSET_W{1'b0}}};
                pend_addr.push_back(acc_addr);
                pend_off.push_back(offset);
                pend_hit.push_back(vec_mem[4*vec_idx+3][0]);
                pend_cycle.push_back(cycle);
                vec_idx++;
                drive_request();
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb/icache_vectors.txt
// tag index offset exp_hit (1 hit, 0 miss), all hex
// cold miss then back-to-back hits on set 05
12345 05 04 0
12345 05 1c 1
12345 05 00 1
12345 05 10 1
// second tag fills way 1
0abcd 05 08 0
12345 05 0c 1
0abcd 05 14 1
// third tag evicts way 0
7f001 05 00 0
0abcd 05 18 1
12345 05 04 0
0abcd 05 00 1
12345 05 08 1
// now way 1 is the victim
7f001 05 00 0
12345 05 1c 1
0abcd 05 00 0
7f001 05 0c 0
// other sets
00abc 7f 00 0
00abc 7f 1c 1
fffff 00 10 0
fffff 00 10 1
12345 7f 04 0
00abc 7f 04 1
12345 7f 08 1
fffff 00 00 1
00000 40 18 0
00000 40 18 1
00000 41 00 0
00000 40 00 1
00000 41 1c 1

// File: project.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_plru.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tb/tb_clock_gen.sv
tb/icache_assert.sv
tb/icache_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := icache_tb
RTL_TOP    := icache_top
FILELIST   := project.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
PASS_MSG   := All checks passed
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
